/* rv_axil_fetch_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_axil_fetch_port
  import rv_fetch_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] miss_addr,
  input  logic                miss_req,
  output logic [`RV_XLEN-1:0] fill_data,
  output logic                fill_valid,
  output axil_ar_t            ar,
  output logic                ar_valid,
  input  logic                ar_ready,
  input  axil_r_t             r,
  input  logic                r_valid,
  output logic                r_ready
);

  axil_state_e state_q;
  axil_ar_t    ar_q;

  assign ar       = ar_q;
  assign ar_valid = (state_q == ax_addr);
  assign r_ready  = (state_q == ax_data);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ax_idle;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= 1'b0;
      case (state_q)
        ax_idle: begin
          // miss_req is still up while the fill pulse is out.
          if (miss_req && !fill_valid) begin
            ar_q.addr <= miss_addr;
            ar_q.prot <= `RV_AXI_PROT_INST;
            state_q   <= ax_addr;
          end
        end
        ax_addr: begin
          if (ar_ready) begin
            state_q <= ax_data;
          end
        end
        ax_data: begin
          // An error response still fills.
          if (r_valid) begin
            fill_data  <= r.data;
            fill_valid <= 1'b1;
            state_q    <= ax_idle;
          end
        end
        default: begin
          state_q <= ax_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rv_fetch.f */
+incdir+.
rv_fetch_pkg.sv
rv_fetch_unit.sv
rv_icache.sv
rv_axil_fetch_port.sv
rv_fetch_top.sv
rv_fetch_sva.sv
rv_fetch_tb.sv

/* rv_fetch_defines.svh */
`ifndef RV_FETCH_DEFINES_SVH
`define RV_FETCH_DEFINES_SVH

// Data and address width.
`define RV_XLEN 32

// First instruction fetched after reset.
`define RV_PC_INIT 32'h0000_0000

// Cache index bits for lines of one word.
`define RV_ICACHE_INDEX_BITS 4

// Full fence.i word with funct3 001 on MISC-MEM.
`define RV_INST_FENCE_I 32'h0000_100f

// AXI prot for an unprivileged, secure instruction access.
`define RV_AXI_PROT_INST 3'b100

`endif

/* rv_fetch_pkg.sv */
`default_nettype none

`include "rv_fetch_defines.svh"

package rv_fetch_pkg;

  // Major opcodes in instruction bits [6:0].
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_op_imm   = 7'b0010011,
    op_auipc    = 7'b0010111,
    op_store    = 7'b0100011,
    op_op       = 7'b0110011,
    op_lui      = 7'b0110111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    ic_idle,
    ic_lookup,
    ic_miss_wait,
    ic_fill
  } icache_state_e;

  typedef enum logic [1:0] {
    ax_idle,
    ax_addr,
    ax_data
  } axil_state_e;

  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [2:0]          prot;
  } axil_ar_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] data;
    logic [1:0]          resp;
  } axil_r_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] inst;
  } fetch_out_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] npc;
    logic                pc_change;
    logic                pc_retire;
    logic                load_retire;
  } redirect_t;

endpackage

`default_nettype wire

/* rv_fetch_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_sva
  import rv_fetch_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input fetch_out_t fetch,
  input logic       fetch_valid,
  input logic       fetch_ready,
  input logic       flush,
  input axil_ar_t   ar,
  input logic       ar_valid,
  input logic       ar_ready,
  input logic       r_ready
);

  property ar_hold;
    @(posedge clock) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar);
  endproperty

  // A flush may withdraw a held instruction.
  property fetch_hold;
    @(posedge clock) disable iff (reset)
      fetch_valid && !fetch_ready |=> flush || (fetch_valid && $stable(fetch));
  endproperty

  property reset_state;
    @(posedge clock) $fell(reset) |-> !fetch_valid && !ar_valid && !flush && !r_ready;
  endproperty

  assert property (ar_hold) else $error("ar_valid or ar changed before ar_ready");
  assert property (fetch_hold) else $error("fetch changed while decode held it off");
  assert property (reset_state) else $error("outputs not idle after reset");

endmodule

bind rv_fetch_top rv_fetch_sva handshake_checks (
  .clock       (clock),
  .reset       (reset),
  .fetch       (fetch),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .flush       (flush),
  .ar          (ar),
  .ar_valid    (ar_valid),
  .ar_ready    (ar_ready),
  .r_ready     (r_ready)
);

`default_nettype wire

/* rv_fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_tb
  import rv_fetch_pkg::*;
();

  // One instruction that still waits for its redirect.
  typedef struct packed {
    logic [31:0] npc;
    logic        change;
    logic        pred;
    logic        wrong;
    logic [6:0]  op;
  } pend_t;

  logic       clock;
  logic       reset;
  fetch_out_t fetch;
  logic       fetch_valid;
  logic       fetch_ready;
  redirect_t  redirect;
  logic       flush;
  axil_ar_t   ar;
  logic       ar_valid;
  logic       ar_ready;
  axil_r_t    r;
  logic       r_valid;
  logic       r_ready;

  logic [31:0] mem [256];
  logic [31:0] tgt_tab [256];
  int          taken_tab [256];
  int          exec_cnt [256];
  int          ar_count [256];
  pend_t       pend [$];
  pend_t       fire_item;
  logic [31:0] exp_pc;
  logic [31:0] tgt_branch;
  logic [31:0] tgt_jal;
  logic [31:0] r_addr;
  logic        spec_open;
  logic        wrong_path;
  logic        blocked;
  logic        fire_now;
  logic        flush_prev;
  logic        r_busy;
  logic        r_done;
  int          r_delay;
  int          res_wait;
  int          mispred_count;
  int          flush_count;
  int          accepted;
  int          discarded;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  string       cur_test;

  rv_fetch_top dut (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .redirect    (redirect),
    .flush       (flush),
    .ar          (ar),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r           (r),
    .r_valid     (r_valid),
    .r_ready     (r_ready)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Unwritten memory reads back as op-imm words.
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], op_op_imm};
  endfunction

  function automatic logic [31:0] mem_read(logic [31:0] addr);
    if (addr < 32'd1024) begin
      return mem[addr[9:2]];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] make_word(opcode_e op);
    logic [31:0] rnd;
    rnd = $urandom();
    return {rnd[24:0], op};
  endfunction

  function automatic opcode_e rand_arith();
    case ($urandom_range(3))
      0: return op_op_imm;
      1: return op_op;
      2: return op_lui;
      default: return op_auipc;
    endcase
  endfunction

  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      mem[i]       = fill_word(i * 4);
      tgt_tab[i]   = '0;
      taken_tab[i] = 0;
      exec_cnt[i]  = 0;
      ar_count[i]  = 0;
    end
  endtask

  task automatic put_word(int addr, logic [31:0] word, int target, int taken);
    mem[addr / 4]       = word;
    tgt_tab[addr / 4]   = target;
    taken_tab[addr / 4] = taken;
  endtask

  task automatic report_value(string what, logic [31:0] expected, logic [31:0] actual);
    $display("Fail %s %s: expected %h actual %h", cur_test, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_problem(string what);
    $display("Error in %s: %s", cur_test, what);
    test_errors++;
  endtask

  task automatic reset_dut();
    @(negedge clock);
    reset       = 1'b1;
    redirect    = '0;
    fetch_ready = 1'b0;
    ar_ready    = 1'b0;
    r_valid     = 1'b0;
    r           = '0;
    pend.delete();
    exp_pc        = `RV_PC_INIT;
    tgt_branch    = `RV_PC_INIT;
    tgt_jal       = `RV_PC_INIT;
    spec_open     = 1'b0;
    wrong_path    = 1'b0;
    blocked       = 1'b0;
    fire_now      = 1'b0;
    flush_prev    = 1'b0;
    r_busy        = 1'b0;
    r_done        = 1'b0;
    res_wait      = 0;
    mispred_count = 0;
    flush_count   = 0;
    accepted      = 0;
    discarded     = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  endtask

  // Back end, decode and memory drive their inputs on the falling edge.
  task automatic drive_inputs();
    redirect    = '0;
    fire_now    = 1'b0;
    fetch_ready = ($urandom_range(3) != 0);
    if (pend.size() > 0) begin
      if (res_wait > 0) begin
        res_wait--;
      end else begin
        fire_now     = 1'b1;
        fire_item    = pend[0];
        redirect.npc = fire_item.npc;
        if (fire_item.op == op_load) begin
          redirect.load_retire = 1'b1;
        end else if (fire_item.change) begin
          redirect.pc_change = 1'b1;
        end else begin
          redirect.pc_retire = 1'b1;
        end
        res_wait = $urandom_range(4);
      end
    end
    if (r_done) begin
      r_valid = 1'b0;
      r_busy  = 1'b0;
      r_done  = 1'b0;
    end
    ar_ready = !r_busy && ($urandom_range(3) != 0);
    if (r_busy && !r_valid) begin
      if (r_delay > 0) begin
        r_delay--;
      end else begin
        r_valid = 1'b1;
        r.data  = mem_read(r_addr);
        r.resp  = 2'b00;
      end
    end
  endtask

  task automatic handle_accept(logic [31:0] pc, logic [31:0] inst);
    logic [31:0] word;
    logic [31:0] npc;
    logic [31:0] ptgt;
    logic        change;
    logic        predicted;
    opcode_e     op;
    pend_t       item;
    int          idx;
    if (wrong_path) begin
      discarded++;
      return;
    end
    if (blocked) begin
      report_problem("an instruction was handed over while fetch should stall");
    end
    word = mem_read(exp_pc);
    if (pc !== exp_pc) begin
      report_value("pc", exp_pc, pc);
    end
    if (inst !== word) begin
      report_value("inst", word, inst);
    end
    accepted++;
    op     = opcode_e'(word[6:0]);
    idx    = exp_pc[9:2];
    npc    = exp_pc + 32'd4;
    change = 1'b0;
    if (op == op_branch) begin
      if (exec_cnt[idx] < taken_tab[idx]) begin
        npc    = tgt_tab[idx];
        change = 1'b1;
      end
      exec_cnt[idx]++;
    end else if (op == op_jal || op == op_jalr) begin
      npc    = tgt_tab[idx];
      change = 1'b1;
    end
    if (spec_open && (op == op_load || op == op_store)) begin
      report_problem("a load or store was handed over during a prediction");
    end
    // Backward taken and forward not taken from the remembered targets.
    ptgt        = (op == op_branch) ? tgt_branch : tgt_jal;
    predicted   = (op == op_branch || op == op_jal) && !spec_open && (ptgt < exp_pc);
    item.npc    = npc;
    item.change = change;
    item.op     = op;
    item.pred   = predicted;
    item.wrong  = predicted && (ptgt != npc);
    if (predicted) begin
      spec_open  = 1'b1;
      wrong_path = item.wrong;
      pend.push_back(item);
    end else if (op inside {op_branch, op_jal, op_jalr, op_system, op_load}) begin
      blocked = 1'b1;
      pend.push_back(item);
    end
    exp_pc = npc;
  endtask

  task automatic apply_resolution();
    pend_t item;
    item = pend.pop_front();
    if (item.pred) begin
      spec_open = 1'b0;
      if (item.wrong) begin
        wrong_path = 1'b0;
        mispred_count++;
      end
    end else begin
      blocked = 1'b0;
    end
    if (item.change || item.wrong) begin
      if (item.op == op_branch) begin
        tgt_branch = item.npc;
      end else if (item.op == op_jal) begin
        tgt_jal = item.npc;
      end
    end
  endtask

  // Outputs have settled for the coming rising edge.
  task automatic sample_cycle();
    if (flush && !flush_prev) begin
      flush_count++;
    end
    flush_prev = flush;
    if (fire_now && (flush !== (fire_item.pred && fire_item.wrong))) begin
      report_value("flush", {31'd0, fire_item.pred && fire_item.wrong}, {31'd0, flush});
    end
    if (ar_valid && ar_ready) begin
      // Instruction access, unprivileged and secure.
      if (ar.prot !== 3'b100) begin
        report_value("ar prot", 32'h4, {29'd0, ar.prot});
      end
      r_busy  = 1'b1;
      r_addr  = ar.addr;
      r_delay = $urandom_range(3);
      if (ar.addr < 32'd1024) begin
        ar_count[ar.addr[9:2]]++;
      end
    end
    if (r_valid && r_ready) begin
      r_done = 1'b1;
    end
    if (fetch_valid && fetch_ready) begin
      handle_accept(fetch.pc, fetch.inst);
    end
    if (fire_now) begin
      apply_resolution();
    end
  endtask

  task automatic run_program(logic [31:0] end_pc);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clock);
      drive_inputs();
      #1;
      if (exp_pc == end_pc && pend.size() == 0 && !wrong_path) begin
        done = 1'b1;
      end else begin
        sample_cycle();
      end
      cycles++;
      if (!done && cycles > 20000) begin
        $display("Timeout: test %s never reached its end address", cur_test);
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
  endtask

  task automatic finish_test();
    if (flush_count != mispred_count) begin
      report_value("flush count", mispred_count, flush_count);
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s passed, %0d accepted, %0d discarded, %0d flushes",
               cur_test, accepted, discarded, flush_count);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic start_test(string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  initial begin
    int seed_value;
    int target;
    int pick;
    seed_value   = $urandom(8);
    reset        = 1'b1;
    redirect     = '0;
    fetch_ready  = 1'b0;
    ar_ready     = 1'b0;
    r_valid      = 1'b0;
    r            = '0;
    tests_passed = 0;
    tests_failed = 0;

    start_test("straight_line");
    clear_program();
    for (int i = 0; i < 24; i++) begin
      put_word(i * 4, make_word(rand_arith()), 0, 0);
    end
    reset_dut();
    run_program(32'd96);
    finish_test();

    start_test("loop_predict");
    clear_program();
    for (int i = 0; i < 6; i++) begin
      put_word(i * 4, make_word(rand_arith()), 0, 0);
    end
    put_word(12, make_word(op_branch), 4, 5);
    reset_dut();
    run_program(32'd24);
    finish_test();

    start_test("cache_hits");
    for (int i = 0; i < 4; i++) begin
      if (ar_count[i] != 1) begin
        report_value("ar count", 1, ar_count[i]);
      end
    end
    finish_test();

    start_test("hazard_stalls");
    clear_program();
    put_word(0, make_word(op_op_imm), 0, 0);
    put_word(4, make_word(op_load), 0, 0);
    put_word(8, make_word(op_store), 0, 0);
    put_word(12, make_word(op_jalr), 24, 0);
    put_word(24, make_word(op_system), 0, 0);
    put_word(28, make_word(op_op), 0, 0);
    reset_dut();
    run_program(32'd32);
    finish_test();

    start_test("fence_i_refetch");
    clear_program();
    put_word(0, make_word(op_op_imm), 0, 0);
    put_word(4, make_word(op_op), 0, 0);
    put_word(8, `RV_INST_FENCE_I, 0, 0);
    put_word(12, make_word(op_branch), 0, 1);
    reset_dut();
    run_program(32'd16);
    if (ar_count[0] < 2 || ar_count[1] < 2) begin
      report_problem("a line cached before fence.i was not fetched again");
    end
    finish_test();

    start_test("random_program");
    clear_program();
    for (int a = 0; a < 48; a++) begin
      pick   = $urandom_range(9);
      target = (a + 1 + $urandom_range(3)) * 4;
      if (target > 192) begin
        target = 192;
      end
      if (pick == 4) begin
        put_word(a * 4, make_word(op_load), 0, 0);
      end else if (pick == 5) begin
        put_word(a * 4, make_word(op_store), 0, 0);
      end else if (pick == 6) begin
        put_word(a * 4, make_word(op_system), 0, 0);
      end else if (pick == 7) begin
        put_word(a * 4, `RV_INST_FENCE_I, 0, 0);
      end else if (pick == 8 && a > 0 && $urandom_range(1) == 1) begin
        put_word(a * 4, make_word(op_branch), $urandom_range(a - 1) * 4, $urandom_range(2));
      end else if (pick == 8) begin
        put_word(a * 4, make_word(op_branch), target, $urandom_range(1));
      end else if (pick == 9 && $urandom_range(1) == 1) begin
        put_word(a * 4, make_word(op_jal), target, 0);
      end else if (pick == 9) begin
        put_word(a * 4, make_word(op_jalr), target, 0);
      end else begin
        put_word(a * 4, make_word(rand_arith()), 0, 0);
      end
    end
    reset_dut();
    run_program(32'd192);
    finish_test();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_top
  import rv_fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  output fetch_out_t fetch,
  output logic       fetch_valid,
  input  logic       fetch_ready,
  input  redirect_t  redirect,
  output logic       flush,
  output axil_ar_t   ar,
  output logic       ar_valid,
  input  logic       ar_ready,
  input  axil_r_t    r,
  input  logic       r_valid,
  output logic       r_ready
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] inst;
  logic                hit_valid;
  logic                icache_ready;
  logic                invalidate;
  logic [`RV_XLEN-1:0] miss_addr;
  logic                miss_req;
  logic [`RV_XLEN-1:0] fill_data;
  logic                fill_valid;

  rv_fetch_unit fetch_unit (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .flush       (flush),
    .pc          (pc),
    .inst        (inst),
    .hit_valid   (hit_valid),
    .cache_ready (icache_ready),
    .invalidate  (invalidate)
  );

  rv_icache icache (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .invalidate (invalidate),
    .inst       (inst),
    .hit_valid  (hit_valid),
    .ready      (icache_ready),
    .miss_addr  (miss_addr),
    .miss_req   (miss_req),
    .fill_data  (fill_data),
    .fill_valid (fill_valid)
  );

  rv_axil_fetch_port axil_port (
    .clock      (clock),
    .reset      (reset),
    .miss_addr  (miss_addr),
    .miss_req   (miss_req),
    .fill_data  (fill_data),
    .fill_valid (fill_valid),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready)
  );

endmodule

`default_nettype wire

/* rv_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_fetch_unit
  import rv_fetch_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  redirect_t           redirect,
  output fetch_out_t          fetch,
  output logic                fetch_valid,
  input  logic                fetch_ready,
  output logic                flush,
  output logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] inst,
  input  logic                hit_valid,
  input  logic                cache_ready,
  output logic                invalidate
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] btb_branch_q;
  logic [`RV_XLEN-1:0] btb_jal_q;
  logic [`RV_XLEN-1:0] spec_target_q;
  logic [`RV_XLEN-1:0] reload_pc_q;
  logic [`RV_XLEN-1:0] branch_target;
  logic                spec_q;
  logic                spec_branch_q;
  logic                stall_q;
  logic                stall_branch_q;
  logic                stall_jal_q;
  logic                load_stall_q;
  logic                reload_q;
  logic                flush_q;

  opcode_e             opcode;
  logic                is_branch;
  logic                is_jal;
  logic                is_jalr;
  logic                is_load;
  logic                is_store;
  logic                is_system;
  logic                is_fence_i;
  logic                predict_taken;
  logic                redirect_any;
  logic                spec_hit;
  logic                mispredict;
  logic                owner_branch;
  logic                owner_jal;
  logic                target_update;
  logic                accept;
  logic                reload_go;

  // Predecode of the word the cache returns for pc_q.
  assign opcode     = opcode_e'(inst[6:0]);
  assign is_branch  = (opcode == op_branch);
  assign is_jal     = (opcode == op_jal);
  assign is_jalr    = (opcode == op_jalr);
  assign is_load    = (opcode == op_load);
  assign is_store   = (opcode == op_store);
  assign is_system  = (opcode == op_system);
  assign is_fence_i = (inst == `RV_INST_FENCE_I);

  // Backward taken, forward not taken.
  assign branch_target = is_branch ? btb_branch_q : btb_jal_q;
  assign predict_taken = (is_branch || is_jal) && !spec_q && (branch_target < pc_q);

  assign redirect_any = redirect.pc_change || redirect.pc_retire;
  assign spec_hit     = spec_q && redirect_any && (redirect.npc == spec_target_q);
  assign mispredict   = spec_q && redirect_any && (redirect.npc != spec_target_q);

  // The next redirect belongs to the prediction if one is open, else to the stall.
  assign owner_branch  = spec_q ? spec_branch_q : stall_branch_q;
  assign owner_jal     = spec_q ? !spec_branch_q : stall_jal_q;
  assign target_update = redirect.pc_change || mispredict;

  assign flush = mispredict || flush_q;

  assign fetch_valid = hit_valid && !stall_q && !load_stall_q && !reload_q && !flush &&
                       !(spec_q && (is_load || is_store));
  assign accept      = fetch_valid && fetch_ready;
  assign invalidate  = accept && is_fence_i;
  assign reload_go   = reload_q && cache_ready && fetch_ready;

  assign fetch.pc   = pc_q;
  assign fetch.inst = inst;
  assign pc         = pc_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q           <= `RV_PC_INIT;
      btb_branch_q   <= `RV_PC_INIT;
      btb_jal_q      <= `RV_PC_INIT;
      spec_q         <= 1'b0;
      spec_branch_q  <= 1'b0;
      stall_q        <= 1'b0;
      stall_branch_q <= 1'b0;
      stall_jal_q    <= 1'b0;
      load_stall_q   <= 1'b0;
      reload_q       <= 1'b0;
      flush_q        <= 1'b0;
    end else begin
      if (target_update) begin
        if (owner_branch) begin
          btb_branch_q <= redirect.npc;
        end
        if (owner_jal) begin
          btb_jal_q <= redirect.npc;
        end
      end

      // Resolve whatever the back end just reported.
      if (mispredict) begin
        spec_q      <= 1'b0;
        stall_q     <= 1'b0;
        flush_q     <= 1'b1;
        reload_q    <= 1'b1;
        reload_pc_q <= redirect.npc;
      end else if (spec_hit) begin
        spec_q <= 1'b0;
      end else if (stall_q && !spec_q && redirect_any) begin
        stall_q     <= 1'b0;
        reload_q    <= 1'b1;
        reload_pc_q <= redirect.npc;
      end else if (load_stall_q && redirect.load_retire) begin
        load_stall_q <= 1'b0;
        reload_q     <= 1'b1;
        reload_pc_q  <= pc_q + 32'd4;
      end

      if (reload_go) begin
        pc_q     <= reload_pc_q;
        reload_q <= 1'b0;
        flush_q  <= 1'b0;
      end else if (accept) begin
        if (is_branch || is_jal) begin
          if (predict_taken) begin
            spec_q        <= 1'b1;
            spec_branch_q <= is_branch;
            spec_target_q <= branch_target;
            pc_q          <= branch_target;
          end else begin
            stall_q        <= 1'b1;
            stall_branch_q <= is_branch;
            stall_jal_q    <= is_jal;
          end
        end else if (is_jalr || is_system) begin
          stall_q        <= 1'b1;
          stall_branch_q <= 1'b0;
          stall_jal_q    <= 1'b0;
        end else if (is_load) begin
          load_stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rv_icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_fetch_defines.svh"

module rv_icache
  import rv_fetch_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic                invalidate,
  output logic [`RV_XLEN-1:0] inst,
  output logic                hit_valid,
  output logic                ready,
  output logic [`RV_XLEN-1:0] miss_addr,
  output logic                miss_req,
  input  logic [`RV_XLEN-1:0] fill_data,
  input  logic                fill_valid
);

  localparam int LINES    = 1 << `RV_ICACHE_INDEX_BITS;
  localparam int TAG_LSB  = `RV_ICACHE_INDEX_BITS + 2;
  localparam int TAG_BITS = `RV_XLEN - TAG_LSB;

  icache_state_e                   state_q;
  logic [TAG_BITS-1:0]             tag_mem [LINES];
  logic [`RV_XLEN-1:0]             data_mem [LINES];
  logic [LINES-1:0]                valid_q;
  logic [`RV_XLEN-1:0]             miss_addr_q;
  logic [`RV_ICACHE_INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]             tag;
  logic [`RV_ICACHE_INDEX_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0]             fill_tag;
  logic                            hit;
  logic                            serving;
  logic                            fill_write;

  assign index      = pc[TAG_LSB-1:2];
  assign tag        = pc[`RV_XLEN-1:TAG_LSB];
  assign fill_index = miss_addr_q[TAG_LSB-1:2];
  assign fill_tag   = miss_addr_q[`RV_XLEN-1:TAG_LSB];

  // Lookup is combinational on the current pc.
  assign hit        = valid_q[index] && (tag_mem[index] == tag);
  assign serving    = (state_q == ic_lookup) || (state_q == ic_fill);
  assign fill_write = (state_q == ic_miss_wait) && fill_valid;

  assign inst      = data_mem[index];
  assign hit_valid = serving && hit;
  assign ready     = (state_q != ic_miss_wait);
  assign miss_req  = (state_q == ic_miss_wait);
  assign miss_addr = miss_addr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ic_idle;
      valid_q <= '0;
    end else begin
      case (state_q)
        ic_idle: begin
          state_q <= ic_lookup;
        end
        ic_lookup, ic_fill: begin
          if (invalidate) begin
            state_q <= ic_idle;
          end else if (!hit) begin
            state_q <= ic_miss_wait;
          end else begin
            state_q <= ic_lookup;
          end
        end
        ic_miss_wait: begin
          if (fill_valid) begin
            state_q <= ic_fill;
          end
        end
        default: begin
          state_q <= ic_idle;
        end
      endcase

      // fence.i wins over a fill in the same cycle.
      if (invalidate) begin
        valid_q <= '0;
      end else if (fill_write) begin
        valid_q[fill_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (serving && !hit && !invalidate) begin
      miss_addr_q <= {pc[`RV_XLEN-1:2], 2'b00};
    end
    if (fill_write) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= fill_data;
    end
  end

endmodule

`default_nettype wire
